// File: all.f
+incdir+.
display_pkg.sv
display_timing.sv
framebuffer_ram.sv
line_scaler.sv
palette_lut.sv
scaled_display_top.sv
tb_scaled_display.sv

// File: display_consts.svh
// raster timing, framebuffer geometry, scale factor and background colour
// for the scaled framebuffer display

`ifndef DISPLAY_CONSTS_SVH
`define DISPLAY_CONSTS_SVH

// horizontal raster, sx runs -H_BLANK .. H_ACTIVE-1
`define H_ACTIVE 640
`define H_BLANK 160

// vertical raster, sy runs -V_BLANK .. V_ACTIVE-1
`define V_ACTIVE 480
`define V_BLANK 45

// framebuffer geometry in source pixels
`define FB_WIDTH 160
`define FB_HEIGHT 120
`define FB_PIXELS 19200  // FB_WIDTH * FB_HEIGHT

// integer upscale, 1 to 4 supported
`define FB_SCALE 3

// active area outside the image
`define BG_COLR 12'h137

// line buffer read runs ahead of the counters:
// one cycle for the line buffer, one for the palette
`define LB_LAT 2

`endif

// File: display_pkg.sv
// shared vector types for the scaled framebuffer display

package display_pkg;

    // signed screen coordinate, blanking is negative
    typedef logic signed [15:0] coord_t;

    // framebuffer address, 19200 entries
    typedef logic [14:0] fb_addr_t;

    // column within one line buffer bank
    typedef logic [7:0] lb_addr_t;

    // palette index stored per source pixel
    typedef logic [3:0] cidx_t;

    // 4:4:4 colour, red in [11:8], green in [7:4], blue in [3:0]
    typedef logic [11:0] colr_t;

    // nibble-doubled output channel
    typedef logic [7:0] chan8_t;

endpackage

// File: display_timing.sv
// free running raster counters for 640x480 with signed coordinates
// de, frame and line strobes registered in step with the counters

`timescale 1ns/1ps

`include "display_consts.svh"

module display_timing
    import display_pkg::*;
(
    input  logic   clk_sys,
    input  logic   rst_n,
    output coord_t sx,     // horizontal position, -160 .. 639
    output coord_t sy,     // vertical position, -45 .. 479
    output logic   de,     // active picture
    output logic   frame,  // first cycle of the frame
    output logic   line    // first cycle of every line
);

    localparam coord_t H_STA = -`H_BLANK;
    localparam coord_t H_END = `H_ACTIVE - 1;
    localparam coord_t V_STA = -`V_BLANK;
    localparam coord_t V_END = `V_ACTIVE - 1;

    coord_t sx_nxt;
    coord_t sy_nxt;

    // next raster position
    always_comb begin
        sx_nxt = sx + 16'sd1;
        sy_nxt = sy;
        if (sx == H_END) begin
            sx_nxt = H_STA;  // wrap line
            sy_nxt = (sy == V_END) ? V_STA : sy + 16'sd1;  // wrap frame
        end
    end

    // strobes decoded from the next position so they line up with sx/sy
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            sx    <= H_STA;
            sy    <= V_STA;
            line  <= 1'b1;  // first cycle out of reset is a frame start
            frame <= 1'b1;
            de    <= 1'b0;
        end else begin
            sx    <= sx_nxt;
            sy    <= sy_nxt;
            line  <= (sx_nxt == H_STA);
            frame <= (sx_nxt == H_STA) && (sy_nxt == V_STA);
            de    <= (sx_nxt >= 0) && (sy_nxt >= 0);
        end
    end

endmodule

// File: framebuffer_ram.sv
// framebuffer of colour indices
// simple dual-port block memory, one write port and a registered read

`timescale 1ns/1ps

`include "display_consts.svh"

module framebuffer_ram
    import display_pkg::*;
(
    input  logic     clk_sys,
    input  logic     we,     // write strobe
    input  fb_addr_t waddr,
    input  cidx_t    wdata,
    input  fb_addr_t raddr,
    output cidx_t    rdata   // one cycle after raddr
);

    cidx_t mem [`FB_PIXELS];  // one index per source pixel

    // write port
    always_ff @(posedge clk_sys) begin
        if (we) mem[waddr] <= wdata;
    end

    // read port, old data on a same-address collision
    always_ff @(posedge clk_sys) begin
        rdata <= mem[raddr];
    end

endmodule

// File: line_scaler.sv
// row fetch from the framebuffer into ping-pong line buffer banks
// and horizontally scaled readout of colour indices

`timescale 1ns/1ps

`include "display_consts.svh"

module line_scaler
    import display_pkg::*;
(
    input  logic     clk_sys,
    input  logic     rst_n,
    input  coord_t   sx,
    input  coord_t   sy,
    input  logic     line,      // start of every line
    input  logic     frame,     // start of frame
    output fb_addr_t fb_raddr,  // framebuffer read address
    input  cidx_t    fb_rdata,  // arrives one cycle after fb_raddr
    output cidx_t    pix_cidx   // index for the palette
);

    localparam int IMG_LINES = `FB_HEIGHT * `FB_SCALE;  // screen lines with image

    // line buffer banks, row r lives in bank r mod 2
    cidx_t bank0 [`FB_WIDTH];
    cidx_t bank1 [`FB_WIDTH];

    logic [2:0] ln_mod;     // (sy+1) mod scale of the previous line
    logic [2:0] ln_cur;     // same for the current line
    logic       fetch_go;   // this line fetches a row
    logic       fetch_busy;
    logic       rd_en;      // framebuffer read this cycle
    lb_addr_t   rd_col;     // column being read from the framebuffer
    logic       fill_bank;  // bank being filled
    logic       wr_en;
    lb_addr_t   wr_col;
    logic       disp_bank;  // bank shown on this line
    lb_addr_t   lb_col;     // readout column
    logic [2:0] sub;        // repeats of the same column

    // line position within a scaled row, row r is fetched on line scale*r-1
    always_comb begin
        if (sy == -16'sd1)
            ln_cur = 3'd0;  // restart ahead of the first image line
        else if (ln_mod == 3'(`FB_SCALE - 1))
            ln_cur = 3'd0;
        else
            ln_cur = ln_mod + 3'd1;
        fetch_go = line && (sy >= -16'sd1) && (sy < IMG_LINES - 1) && (ln_cur == 3'd0);
        rd_en    = fetch_go || fetch_busy;
    end

    // fetch control, 160 reads starting on the line pulse
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            ln_mod     <= 3'd0;
            fetch_busy <= 1'b0;
            rd_col     <= '0;
            fill_bank  <= 1'b0;
            disp_bank  <= 1'b0;
        end else begin
            if (line) begin
                ln_mod    <= ln_cur;
                disp_bank <= fill_bank;  // row fetched on the line before
            end
            if (fetch_go)
                fill_bank <= (sy == -16'sd1) ? 1'b0 : ~fill_bank;  // row 0 to bank 0
            if (rd_en) begin
                if (rd_col == lb_addr_t'(`FB_WIDTH - 1)) begin
                    rd_col     <= '0;
                    fetch_busy <= 1'b0;
                end else begin
                    rd_col     <= rd_col + 1'b1;
                    fetch_busy <= 1'b1;
                end
            end
        end
    end

    // address walks through the image, +160 per fetched row
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n)
            fb_raddr <= '0;
        else if (frame)
            fb_raddr <= '0;
        else if (rd_en)
            fb_raddr <= fb_raddr + 1'b1;
    end

    // bank write trails the read by the ram latency
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n)
            wr_en <= 1'b0;
        else
            wr_en <= rd_en;
    end

    always_ff @(posedge clk_sys) begin
        wr_col <= rd_col;
        if (wr_en) begin
            if (fill_bank)
                bank1[wr_col] <= fb_rdata;
            else
                bank0[wr_col] <= fb_rdata;
        end
    end

    // readout column, starts LB_LAT cycles before sx = 0
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            lb_col <= '0;
            sub    <= 3'd0;
        end else if (line) begin
            lb_col <= '0;
            sub    <= 3'd0;
        end else if (sx >= -`LB_LAT) begin
            if (sub == 3'(`FB_SCALE - 1)) begin
                sub <= 3'd0;
                if (lb_col != lb_addr_t'(`FB_WIDTH - 1))
                    lb_col <= lb_col + 1'b1;  // hold at the right edge
            end else begin
                sub <= sub + 3'd1;
            end
        end
    end

    // registered bank read, one cycle ahead of the palette
    always_ff @(posedge clk_sys) begin
        pix_cidx <= disp_bank ? bank1[lb_col] : bank0[lb_col];
    end

endmodule

// File: palette_lut.sv
// 16-entry writable colour lookup table
// cleared at reset, registered read

`timescale 1ns/1ps

module palette_lut
    import display_pkg::*;
(
    input  logic   clk_sys,
    input  logic   rst_n,
    input  logic   we,     // write strobe
    input  cidx_t  widx,
    input  colr_t  wcolr,
    input  cidx_t  ridx,
    output colr_t  rcolr   // one cycle after ridx
);

    colr_t table_q [16];

    // table writes, all black after reset
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++)
                table_q[i] <= '0;
        end else if (we) begin
            table_q[widx] <= wcolr;
        end
    end

    // lookup, a write shows from the next cycle's read onward
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n)
            rcolr <= '0;
        else
            rcolr <= table_q[ridx];
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the scaled display testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_scaled_display -Mdir obj_dir -f all.f

# the simulator exits non-zero on a fatal error, the search below decides
out=$(./obj_dir/Vtb_scaled_display 2>&1) || true
echo "$out"

if echo "$out" | grep -qF "=== PASS ==="; then
    exit 0
else
    exit 1
fi

// File: scaled_display_top.sv
// scaled framebuffer display top level
// timing, framebuffer, line scaler, palette and the registered output stage

`timescale 1ns/1ps

`include "display_consts.svh"

module scaled_display_top
    import display_pkg::*;
(
    input  logic     clk_sys,
    input  logic     rst_n,
    input  logic     fb_we,       // framebuffer write strobe
    input  fb_addr_t fb_waddr,
    input  cidx_t    fb_wdata,
    input  logic     clut_we,     // palette write strobe
    input  cidx_t    clut_widx,
    input  colr_t    clut_wcolr,
    output coord_t   sdl_sx,
    output coord_t   sdl_sy,
    output logic     sdl_de,
    output logic     sdl_frame,
    output chan8_t   sdl_r,
    output chan8_t   sdl_g,
    output chan8_t   sdl_b
);

    localparam int IMG_W = `FB_WIDTH * `FB_SCALE;   // scaled image width
    localparam int IMG_H = `FB_HEIGHT * `FB_SCALE;  // scaled image height

    coord_t   sx;
    coord_t   sy;
    logic     de;
    logic     frame;
    logic     line;
    fb_addr_t fb_raddr;
    cidx_t    fb_rdata;
    cidx_t    pix_cidx;
    colr_t    pix_colr;   // palette colour for the pixel at sx/sy
    logic     paint_area;
    colr_t    disp_colr;

    display_timing display_timing_i (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .sx      (sx),
        .sy      (sy),
        .de      (de),
        .frame   (frame),
        .line    (line)
    );

    framebuffer_ram framebuffer_ram_i (
        .clk_sys (clk_sys),
        .we      (fb_we),
        .waddr   (fb_waddr),
        .wdata   (fb_wdata),
        .raddr   (fb_raddr),
        .rdata   (fb_rdata)
    );

    line_scaler line_scaler_i (
        .clk_sys  (clk_sys),
        .rst_n    (rst_n),
        .sx       (sx),
        .sy       (sy),
        .line     (line),
        .frame    (frame),
        .fb_raddr (fb_raddr),
        .fb_rdata (fb_rdata),
        .pix_cidx (pix_cidx)
    );

    palette_lut palette_lut_i (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .we      (clut_we),
        .widx    (clut_widx),
        .wcolr   (clut_wcolr),
        .ridx    (pix_cidx),
        .rcolr   (pix_colr)
    );

    // image at top left, background elsewhere, black in blanking
    always_comb begin
        paint_area = de && (sx < IMG_W) && (sy < IMG_H);  // de covers sx, sy >= 0
        if (!de)
            disp_colr = '0;
        else if (paint_area)
            disp_colr = pix_colr;
        else
            disp_colr = `BG_COLR;
    end

    // output stage, channels widened by repeating the nibble
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            sdl_sx    <= '0;
            sdl_sy    <= '0;
            sdl_de    <= 1'b0;
            sdl_frame <= 1'b0;
            sdl_r     <= '0;
            sdl_g     <= '0;
            sdl_b     <= '0;
        end else begin
            sdl_sx    <= sx;
            sdl_sy    <= sy;
            sdl_de    <= de;
            sdl_frame <= frame;
            sdl_r     <= {2{disp_colr[11:8]}};
            sdl_g     <= {2{disp_colr[7:4]}};
            sdl_b     <= {2{disp_colr[3:0]}};
        end
    end

endmodule

// File: tb_scaled_display.sv
// testbench for the scaled framebuffer display
// random image and palette load, reference model, compare tasks, timeouts

`timescale 1ns/1ps

`include "display_consts.svh"

module tb_scaled_display
    import display_pkg::*;
();

    localparam int FRAME_CYCLES = (`H_ACTIVE + `H_BLANK) * (`V_ACTIVE + `V_BLANK);
    localparam int IMG_W = `FB_WIDTH * `FB_SCALE;
    localparam int IMG_H = `FB_HEIGHT * `FB_SCALE;
    localparam int WAIT_LIMIT = FRAME_CYCLES + 1000;  // cycles per frame wait

    logic     clk_sys;
    logic     rst_n;
    logic     fb_we;
    fb_addr_t fb_waddr;
    cidx_t    fb_wdata;
    logic     clut_we;
    cidx_t    clut_widx;
    colr_t    clut_wcolr;
    coord_t   sdl_sx;
    coord_t   sdl_sy;
    logic     sdl_de;
    logic     sdl_frame;
    chan8_t   sdl_r;
    chan8_t   sdl_g;
    chan8_t   sdl_b;

    // reference model of the memories
    cidx_t model_fb [`FB_PIXELS];
    colr_t model_pal [16];

    bit started;      // first frame strobe seen
    int frame_num;    // index of the frame on the outputs
    int prev_x;
    int prev_y;

    scaled_display_top scaled_display_top_i (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .fb_we      (fb_we),
        .fb_waddr   (fb_waddr),
        .fb_wdata   (fb_wdata),
        .clut_we    (clut_we),
        .clut_widx  (clut_widx),
        .clut_wcolr (clut_wcolr),
        .sdl_sx     (sdl_sx),
        .sdl_sy     (sdl_sy),
        .sdl_de     (sdl_de),
        .sdl_frame  (sdl_frame),
        .sdl_r      (sdl_r),
        .sdl_g      (sdl_g),
        .sdl_b      (sdl_b)
    );

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;  // 8 ns period
    end

    task automatic stop_with_failure;
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_colr(input string name, input chan8_t exp, input chan8_t act);
        if (exp !== act) begin
            $display("ERROR %s expected %h got %h at sx %h sy %h", name, exp, act, sdl_sx, sdl_sy);
            stop_with_failure();
        end
    endtask

    task automatic check_coord(input string name, input coord_t exp, input coord_t act);
        if (exp !== act) begin
            $display("ERROR %s expected %h got %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERROR %s expected %h got %h at sx %h sy %h", name, exp, act, sdl_sx, sdl_sy);
            stop_with_failure();
        end
    endtask

    function automatic bit in_image(input int x, input int y);
        return (x >= 0) && (y >= 0) && (x < IMG_W) && (y < IMG_H);
    endfunction

    // black in blanking, image at top left, background elsewhere
    function automatic colr_t expected_colr(input int x, input int y);
        if (!((x >= 0) && (y >= 0)))
            return 12'h000;
        if (in_image(x, y))
            return model_pal[model_fb[(y / `FB_SCALE) * `FB_WIDTH + x / `FB_SCALE]];
        return `BG_COLR;
    endfunction

    // one output cycle against the model
    task automatic check_cycle;
        int    x;
        int    y;
        int    nx;
        int    ny;
        colr_t exp_c;
        x = int'(sdl_sx);
        y = int'(sdl_sy);
        if (started) begin
            nx = prev_x + 1;  // raster step from the last cycle
            ny = prev_y;
            if (nx == `H_ACTIVE) begin
                nx = -`H_BLANK;
                ny = (prev_y == `V_ACTIVE - 1) ? -`V_BLANK : prev_y + 1;
            end
            check_coord("sdl_sx", coord_t'(nx), sdl_sx);
            check_coord("sdl_sy", coord_t'(ny), sdl_sy);
            check_flag("sdl_frame", (nx == -`H_BLANK) && (ny == -`V_BLANK), sdl_frame);
        end
        if (sdl_frame) begin
            if (!started) begin
                check_coord("sdl_sx", coord_t'(-`H_BLANK), sdl_sx);  // first strobe
                check_coord("sdl_sy", coord_t'(-`V_BLANK), sdl_sy);
            end
            started   = 1'b1;
            frame_num = frame_num + 1;
        end
        check_flag("sdl_de", (x >= 0) && (y >= 0), sdl_de);
        if ((frame_num >= 1) || !in_image(x, y)) begin  // image unloaded in frame 0
            exp_c = expected_colr(x, y);
            check_colr("sdl_r", chan8_t'({exp_c[11:8], exp_c[11:8]}), sdl_r);
            check_colr("sdl_g", chan8_t'({exp_c[7:4], exp_c[7:4]}), sdl_g);
            check_colr("sdl_b", chan8_t'({exp_c[3:0], exp_c[3:0]}), sdl_b);
        end
        prev_x = x;
        prev_y = y;
    endtask

    // every output cycle compared on the falling edge
    always @(negedge clk_sys) begin
        if (rst_n && (started || sdl_frame))
            check_cycle();
    end

    task automatic wait_for_frame(input int n, input int limit, input string what);
        int cnt;
        cnt = 0;
        while (frame_num < n) begin
            if (cnt >= limit) begin
                $display("timeout while waiting for %s", what);
                stop_with_failure();
            end
            @(posedge clk_sys);
            cnt++;
        end
    endtask

    task automatic write_fb(input int addr, input cidx_t data);
        @(posedge clk_sys);
        fb_we    <= 1'b1;
        fb_waddr <= fb_addr_t'(addr);
        fb_wdata <= data;
        clut_we  <= 1'b0;
        model_fb[addr] = data;
    endtask

    task automatic write_clut(input cidx_t idx, input colr_t colr);
        @(posedge clk_sys);
        clut_we    <= 1'b1;
        clut_widx  <= idx;
        clut_wcolr <= colr;
        fb_we      <= 1'b0;
        model_pal[idx] = colr;
    endtask

    task automatic release_strobes;
        @(posedge clk_sys);
        fb_we   <= 1'b0;
        clut_we <= 1'b0;
    endtask

    initial begin
        int addr;
        void'($urandom(32'h6f957502));
        rst_n      = 1'b0;
        fb_we      = 1'b0;
        fb_waddr   = '0;
        fb_wdata   = '0;
        clut_we    = 1'b0;
        clut_widx  = '0;
        clut_wcolr = '0;
        started     = 1'b0;
        frame_num   = -1;
        prev_x      = 0;
        prev_y      = 0;
        for (int i = 0; i < `FB_PIXELS; i++)
            model_fb[i] = '0;
        for (int i = 0; i < 16; i++)
            model_pal[i] = '0;  // palette clears at reset

        repeat (5) @(posedge clk_sys);
        rst_n <= 1'b1;
        @(negedge clk_sys);
        check_flag("sdl_de", 1'b0, sdl_de);  // still idle after reset
        check_flag("sdl_frame", 1'b0, sdl_frame);
        wait_for_frame(0, 16, "the first frame strobe");

        // whole image and palette loaded in frame 0 before row 0 is fetched
        for (int i = 0; i < `FB_PIXELS; i++)
            write_fb(i, cidx_t'($urandom));
        for (int i = 0; i < 16; i++)
            write_clut(cidx_t'(i), colr_t'($urandom));
        release_strobes();

        wait_for_frame(1, WAIT_LIMIT, "frame 1");
        wait_for_frame(2, WAIT_LIMIT, "frame 2");

        // partial palette and pixel rewrite in the vertical blanking of frame 2
        for (int i = 0; i < 8; i++)
            write_clut(cidx_t'($urandom), colr_t'($urandom));
        for (int i = 0; i < 300; i++) begin
            if (i % 4 == 0)
                addr = int'($urandom % `FB_WIDTH);  // first row
            else if (i % 4 == 1)
                addr = (`FB_HEIGHT - 1) * `FB_WIDTH + int'($urandom % `FB_WIDTH);  // last row
            else
                addr = int'($urandom % `FB_PIXELS);
            write_fb(addr, cidx_t'($urandom));
        end
        release_strobes();

        wait_for_frame(3, WAIT_LIMIT, "the end of frame 2");
        $display("=== PASS ===");
        $finish;
    end

endmodule
